//--- src.f
+incdir+verilog
verilog/nes_pad_pkg.sv
verilog/pad_sync.sv
verilog/turbo_mix.sv
verilog/joypad_shift.sv
verilog/nes_pad_top.sv
sim/tb_nes_pad.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the NES pad testbench with Verilator
# pass or fail is taken from the simulation log

cd "$(dirname "$0")" || exit 1
mkdir -p build || exit 1

verilator --binary --timing -f src.f --top-module tb_nes_pad \
    -Mdir build -o tb_nes_pad > build/compile.log 2>&1 \
    || { cat build/compile.log; echo "verilator build failed"; exit 1; }

./build/tb_nes_pad > build/sim.log 2>&1
cat build/sim.log

grep -q "Something failed" build/sim.log && { echo "simulation reported a failure"; exit 1; }
grep -q "Everything OK" build/sim.log || { echo "simulation ended without a pass line"; exit 1; }
echo "simulation passed"

//--- sim/tb_nes_pad.sv
// Testbench for the NES pad path
// reads both serial joypad ports and compares them with a reference
// mapping, then checks the home combination and autofire

`timescale 1ns/1ps

`include "nes_pad_config.svh"

module tb_nes_pad;

    localparam int CLK_PERIOD      = 10;
    localparam int RANDOM_SETS     = 50;
    localparam int SWAP_SETS       = 10;
    localparam int TURBO_READS     = 12;
    localparam int RELEASE_READS   = 4;
    localparam int TURBO_PERIOD    = 2 * `NES_PAD_TURBO_HALF;
    localparam int CYCLES_PER_READ = 3 + 16 * 5;   // strobe, then 16 clocked bits
    localparam int NUM_READS       = 2 * (RANDOM_SETS + SWAP_SETS + TURBO_READS + RELEASE_READS);

    logic                       clk;
    logic                       sys_resetn;
    nes_pad_pkg::snes_buttons_t pad1_buttons;
    nes_pad_pkg::snes_buttons_t pad2_buttons;
    logic                       pad_swap;
    logic                       joypad_strobe;
    logic [1:0]                 joypad_clock;
    logic                       joypad1_data;
    logic                       joypad2_data;
    logic                       home_press;

    // results waiting for the compare process
    nes_pad_pkg::nes_buttons_t nes_got_q[$];
    nes_pad_pkg::nes_buttons_t nes_exp_q[$];
    string                     nes_name_q[$];
    logic                      bit_got_q[$];
    logic                      bit_exp_q[$];
    string                     bit_name_q[$];

    nes_pad_top UUT (
        .clk           (clk),
        .sys_resetn    (sys_resetn),
        .pad1_buttons  (pad1_buttons),
        .pad2_buttons  (pad2_buttons),
        .pad_swap      (pad_swap),
        .joypad_strobe (joypad_strobe),
        .joypad_clock  (joypad_clock),
        .joypad1_data  (joypad1_data),
        .joypad2_data  (joypad2_data),
        .home_press    (home_press)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    ////////////////////////////////////////////////////////////
    // reference and compare
    ////////////////////////////////////////////////////////////

    // SNES layout to NES byte with autofire off
    function automatic nes_pad_pkg::nes_buttons_t expected_nes(
        input nes_pad_pkg::snes_buttons_t s);
        nes_pad_pkg::nes_buttons_t n;
        n.right  = s.right;
        n.left   = s.left;
        n.down   = s.down;
        n.up     = s.up;
        n.start  = s.start;
        n.select = s.select;
        n.b      = s.b;
        n.a      = s.a;
        return n;
    endfunction

    task automatic report_failure(input string reason);
        $display("%s", reason);
        $display("Something failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_nes(input string name, input nes_pad_pkg::nes_buttons_t got,
                             input nes_pad_pkg::nes_buttons_t exp);
        if (got !== exp) begin
            report_failure($sformatf("mismatch %s: got %h expected %h", name, got, exp));
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            report_failure($sformatf("mismatch %s: got %h expected %h", name, got, exp));
        end
    endtask

    task automatic queue_nes(input string name, input nes_pad_pkg::nes_buttons_t got,
                             input nes_pad_pkg::nes_buttons_t exp);
        nes_name_q.push_back(name);
        nes_got_q.push_back(got);
        nes_exp_q.push_back(exp);
    endtask

    task automatic queue_bit(input string name, input logic got, input logic exp);
        bit_name_q.push_back(name);
        bit_got_q.push_back(got);
        bit_exp_q.push_back(exp);
    endtask

    // byte lsb first, then ones behind the last button
    task automatic expect_stream(input string name, input logic [15:0] bits,
                                 input nes_pad_pkg::nes_buttons_t exp);
        queue_nes(name, nes_pad_pkg::nes_buttons_t'(bits[7:0]), exp);
        for (int i = 8; i < 16; i++) begin
            queue_bit($sformatf("%s bit %0d", name, i + 1), bits[i], 1'b1);
        end
    endtask

    // compare process draining at the falling edge
    initial begin
        forever begin
            @(negedge clk);
            while (nes_got_q.size() > 0) begin
                check_nes(nes_name_q.pop_front(), nes_got_q.pop_front(), nes_exp_q.pop_front());
            end
            while (bit_got_q.size() > 0) begin
                check_bit(bit_name_q.pop_front(), bit_got_q.pop_front(), bit_exp_q.pop_front());
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // stimulus helpers
    ////////////////////////////////////////////////////////////

    function automatic nes_pad_pkg::snes_buttons_t random_pad();
        nes_pad_pkg::snes_buttons_t p;
        p = 12'($urandom);
        p.turbo_a = 1'b0;    // autofire off for plain reads
        p.turbo_b = 1'b0;
        return p;
    endfunction

    task automatic set_pads(input nes_pad_pkg::snes_buttons_t p1,
                            input nes_pad_pkg::snes_buttons_t p2, input logic swap);
        @(posedge clk);
        pad1_buttons <= p1;
        pad2_buttons <= p2;
        pad_swap     <= swap;
        repeat (6) @(posedge clk);   // sync, home flag and mapping settle
    endtask

    task automatic read_port(input logic port, output logic [15:0] bits);
        @(posedge clk);
        joypad_strobe <= 1'b1;
        repeat (2) @(posedge clk);
        joypad_strobe <= 1'b0;                        // byte latched
        for (int i = 0; i < 16; i++) begin
            @(negedge clk);
            bits[i] = port ? joypad2_data : joypad1_data;
            @(posedge clk);
            joypad_clock[port] <= 1'b1;
            repeat (2) @(posedge clk);
            joypad_clock[port] <= 1'b0;
            repeat (2) @(posedge clk);                // shift lands a cycle after the fall
        end
    endtask

    task automatic home_case(input nes_pad_pkg::snes_buttons_t p1,
                             input nes_pad_pkg::snes_buttons_t p2,
                             input logic swap, input logic exp);
        set_pads(p1, p2, swap);
        @(negedge clk);
        queue_bit("home_press", home_press, exp);
    endtask

    // autofire on one pad with a on port 1 or b on port 2
    task automatic test_turbo(input logic port, input logic use_b);
        nes_pad_pkg::snes_buttons_t pad;
        nes_pad_pkg::snes_buttons_t other;
        nes_pad_pkg::nes_buttons_t  exp;
        nes_pad_pkg::nes_buttons_t  got;
        logic [15:0]                bits;
        logic                       turbo_bit;
        int                         ones;
        int                         zeros;
        string                      name;
        pad   = random_pad();
        other = random_pad();
        ones  = 0;
        zeros = 0;
        name  = port ? "joypad2_data" : "joypad1_data";
        if (use_b) begin
            pad.b       = 1'b0;
            pad.turbo_b = 1'b1;
        end else begin
            pad.a       = 1'b0;
            pad.turbo_a = 1'b1;
        end
        if (port) set_pads(other, pad, 1'b0);
        else set_pads(pad, other, 1'b0);
        exp = expected_nes(pad);
        for (int i = 0; i < TURBO_READS; i++) begin
            repeat (i % TURBO_PERIOD) @(posedge clk);   // walk the load across the period
            read_port(port, bits);
            got       = nes_pad_pkg::nes_buttons_t'(bits[7:0]);
            turbo_bit = use_b ? got.b : got.a;
            if (turbo_bit) ones++;
            else zeros++;
            // rest of the byte stays put
            if (use_b) got.b = exp.b;
            else got.a = exp.a;
            queue_nes(name, got, exp);
        end
        if (ones == 0 || zeros == 0) begin
            report_failure($sformatf("autofire on %s did not toggle over %0d reads",
                                     use_b ? "b" : "a", TURBO_READS));
        end
        // after release the bit stays low
        pad.turbo_a = 1'b0;
        pad.turbo_b = 1'b0;
        if (port) set_pads(other, pad, 1'b0);
        else set_pads(pad, other, 1'b0);
        for (int i = 0; i < RELEASE_READS; i++) begin
            read_port(port, bits);
            expect_stream(name, bits, expected_nes(pad));
        end
    endtask

    ////////////////////////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////////////////////////

    initial begin
        nes_pad_pkg::snes_buttons_t p1;
        nes_pad_pkg::snes_buttons_t p2;
        nes_pad_pkg::snes_buttons_t sel_down;
        nes_pad_pkg::snes_buttons_t down_only;
        nes_pad_pkg::snes_buttons_t sel_only;
        logic [15:0]                bits;
        void'($urandom(32'he921));
        sys_resetn    = 1'b0;
        pad1_buttons  = '0;
        pad2_buttons  = '0;
        pad_swap      = 1'b0;
        joypad_strobe = 1'b0;
        joypad_clock  = 2'b00;
        repeat (16) @(posedge clk);
        sys_resetn <= 1'b1;

        // idle after reset
        repeat (4) @(posedge clk);
        @(negedge clk);
        queue_bit("joypad1_data", joypad1_data, 1'b1);
        queue_bit("joypad2_data", joypad2_data, 1'b1);
        queue_bit("home_press", home_press, 1'b0);

        for (int n = 0; n < RANDOM_SETS; n++) begin
            p1 = random_pad();
            p2 = random_pad();
            set_pads(p1, p2, 1'b0);
            read_port(1'b0, bits);
            expect_stream("joypad1_data", bits, expected_nes(p1));
            read_port(1'b1, bits);
            expect_stream("joypad2_data", bits, expected_nes(p2));
        end

        // swapped pads cross over
        for (int n = 0; n < SWAP_SETS; n++) begin
            p1 = random_pad();
            p2 = random_pad();
            set_pads(p1, p2, 1'b1);
            read_port(1'b0, bits);
            expect_stream("joypad1_data", bits, expected_nes(p2));
            read_port(1'b1, bits);
            expect_stream("joypad2_data", bits, expected_nes(p1));
        end

        // home combination of select + down
        sel_down        = '0;
        sel_down.select = 1'b1;
        sel_down.down   = 1'b1;
        down_only       = '0;
        down_only.down  = 1'b1;
        sel_only        = '0;
        sel_only.select = 1'b1;
        home_case(sel_down, '0, 1'b0, 1'b1);
        home_case(down_only, '0, 1'b0, 1'b0);
        home_case(sel_down, '0, 1'b0, 1'b1);
        home_case(sel_only, '0, 1'b0, 1'b0);
        home_case(sel_down, '0, 1'b1, 1'b0);        // pad 1 moved to port 2
        home_case('0, sel_down, 1'b1, 1'b1);
        home_case('0, sel_only, 1'b1, 1'b0);

        test_turbo(1'b0, 1'b0);
        test_turbo(1'b1, 1'b1);

        repeat (2) @(negedge clk);                  // compare process drains
        $display("Everything OK");
        $finish;
    end

    // watchdog
    initial begin
        #(NUM_READS * CYCLES_PER_READ * 2 * CLK_PERIOD);
        report_failure($sformatf("timeout, tests still running after %0d ns",
                                 NUM_READS * CYCLES_PER_READ * 2 * CLK_PERIOD));
    end

endmodule

//--- verilog/nes_pad_top.sv
// NES pad top level
// two SNES style pads through sync, autofire and the two serial
// joypad ports seen by the console, plus the home combination level

`timescale 1ns/1ps

module nes_pad_top (
    input  logic                       clk,
    input  logic                       sys_resetn,
    input  nes_pad_pkg::snes_buttons_t pad1_buttons,
    input  nes_pad_pkg::snes_buttons_t pad2_buttons,
    input  logic                       pad_swap,
    input  logic                       joypad_strobe,
    input  logic [1:0]                 joypad_clock,   // bit 0 port 1, bit 1 port 2
    output logic                       joypad1_data,
    output logic                       joypad2_data,
    output logic                       home_press
);

    nes_pad_pkg::snes_buttons_t sync_pad1;   // after sync and swap
    nes_pad_pkg::snes_buttons_t sync_pad2;
    nes_pad_pkg::nes_buttons_t  nes_pad1;    // NES byte with autofire
    nes_pad_pkg::nes_buttons_t  nes_pad2;

    ////////////////////////////////////////////////////////////
    // input side
    ////////////////////////////////////////////////////////////

    pad_sync u_pad_sync (
        .clk          (clk),
        .sys_resetn   (sys_resetn),
        .pad1_buttons (pad1_buttons),
        .pad2_buttons (pad2_buttons),
        .pad_swap     (pad_swap),
        .sync_pad1    (sync_pad1),
        .sync_pad2    (sync_pad2),
        .home_press   (home_press)
    );

    ////////////////////////////////////////////////////////////
    // autofire, one per pad
    ////////////////////////////////////////////////////////////

    turbo_mix u_turbo_mix1 (
        .clk        (clk),
        .sys_resetn (sys_resetn),
        .pad        (sync_pad1),
        .nes_pad    (nes_pad1)
    );

    turbo_mix u_turbo_mix2 (
        .clk        (clk),
        .sys_resetn (sys_resetn),
        .pad        (sync_pad2),
        .nes_pad    (nes_pad2)
    );

    ////////////////////////////////////////////////////////////
    // console joypad ports
    ////////////////////////////////////////////////////////////

    joypad_shift u_joypad1 (
        .clk        (clk),
        .sys_resetn (sys_resetn),
        .nes_pad    (nes_pad1),
        .strobe     (joypad_strobe),     // shared strobe
        .port_clock (joypad_clock[0]),
        .data       (joypad1_data)
    );

    joypad_shift u_joypad2 (
        .clk        (clk),
        .sys_resetn (sys_resetn),
        .nes_pad    (nes_pad2),
        .strobe     (joypad_strobe),
        .port_clock (joypad_clock[1]),
        .data       (joypad2_data)
    );

endmodule

//--- verilog/joypad_shift.sv
// NES joypad port
// strobe loads the button byte, each falling edge of the port clock
// shifts the next bit out, ones follow the last button

`timescale 1ns/1ps

`include "nes_pad_config.svh"

module joypad_shift (
    input  logic                      clk,
    input  logic                      sys_resetn,
    input  nes_pad_pkg::nes_buttons_t nes_pad,
    input  logic                      strobe,      // loads while high
    input  logic                      port_clock,  // console side shift clock
    output logic                      data
);

    nes_pad_pkg::nes_byte_t shift_reg;
    logic                   last_clock;   // port_clock one cycle ago
    logic                   clock_fall;

    assign clock_fall = last_clock & ~port_clock;

    ////////////////////////////////////////////////////////////
    // shift register
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!sys_resetn) begin
            shift_reg  <= '1;             // idle line reads 1
            last_clock <= 1'b0;
        end else begin
            last_clock <= port_clock;
            if (clock_fall) begin
                // shift wins over a load in the same cycle
                shift_reg <= {1'b1, shift_reg[`NES_PAD_BITS-1:1]};
            end else if (strobe) begin
                shift_reg <= nes_pad_pkg::nes_byte_t'(nes_pad);  // a lands in bit 0
            end
        end
    end

    assign data = shift_reg[0];   // current button on the wire

endmodule

//--- verilog/turbo_mix.sv
// Turbo mixer for one pad
// runs the autofire counters for turbo a / turbo b and folds them
// into the NES a and b buttons of the registered joypad byte

`timescale 1ns/1ps

`include "nes_pad_config.svh"

module turbo_mix (
    input  logic                       clk,
    input  logic                       sys_resetn,
    input  nes_pad_pkg::snes_buttons_t pad,
    output nes_pad_pkg::nes_buttons_t  nes_pad
);

    localparam int HALF  = `NES_PAD_TURBO_HALF;
    localparam int CNT_W = $clog2(2 * HALF);

    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(2 * HALF - 1);  // wrap point
    localparam logic [CNT_W-1:0] CNT_HALF = CNT_W'(HALF);          // high / low split

    // index 0 is turbo a, index 1 is turbo b
    logic [1:0]       turbo_held;
    logic [CNT_W-1:0] turbo_cnt [2];
    logic [1:0]       autofire;

    assign turbo_held = {pad.turbo_b, pad.turbo_a};

    ////////////////////////////////////////////////////////////
    // autofire counters
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!sys_resetn) begin
            for (int i = 0; i < 2; i++) begin
                turbo_cnt[i] <= '0;
            end
        end else begin
            for (int i = 0; i < 2; i++) begin
                if (!turbo_held[i]) begin
                    turbo_cnt[i] <= '0;                       // restart on release
                end else if (turbo_cnt[i] == CNT_LAST) begin
                    turbo_cnt[i] <= '0;                       // one full period done
                end else begin
                    turbo_cnt[i] <= turbo_cnt[i] + 1'b1;
                end
            end
        end
    end

    // first half of the period is pressed
    always_comb begin
        for (int i = 0; i < 2; i++) begin
            autofire[i] = turbo_held[i] & (turbo_cnt[i] < CNT_HALF);
        end
    end

    ////////////////////////////////////////////////////////////
    // SNES to NES mapping
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!sys_resetn) begin
            nes_pad <= '0;
        end else begin
            nes_pad.right  <= pad.right;
            nes_pad.left   <= pad.left;
            nes_pad.down   <= pad.down;
            nes_pad.up     <= pad.up;
            nes_pad.start  <= pad.start;
            nes_pad.select <= pad.select;
            nes_pad.b      <= pad.b | autofire[1];  // turbo b merged
            nes_pad.a      <= pad.a | autofire[0];  // turbo a merged
        end
    end

endmodule

//--- verilog/pad_sync.sv
// Pad synchronizer
// brings both pads and the swap level into clk, swaps pads on request
// and flags the home combination (select + down on pad 1)

`timescale 1ns/1ps

`include "nes_pad_config.svh"

module pad_sync (
    input  logic                       clk,
    input  logic                       sys_resetn,
    input  nes_pad_pkg::snes_buttons_t pad1_buttons,  // async levels
    input  nes_pad_pkg::snes_buttons_t pad2_buttons,
    input  logic                       pad_swap,
    output nes_pad_pkg::snes_buttons_t sync_pad1,
    output nes_pad_pkg::snes_buttons_t sync_pad2,
    output logic                       home_press
);

    localparam int STAGES = `NES_PAD_SYNC_STAGES;

    // stage 0 takes the raw input, stage STAGES-1 is the settled copy
    nes_pad_pkg::snes_buttons_t [STAGES-1:0] pad1_sync;
    nes_pad_pkg::snes_buttons_t [STAGES-1:0] pad2_sync;
    logic [STAGES-1:0]                       swap_sync;

    ////////////////////////////////////////////////////////////
    // synchronizer chains
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!sys_resetn) begin
            pad1_sync <= '0;
            pad2_sync <= '0;
            swap_sync <= '0;
        end else begin
            pad1_sync <= {pad1_sync[STAGES-2:0], pad1_buttons};
            pad2_sync <= {pad2_sync[STAGES-2:0], pad2_buttons};
            swap_sync <= {swap_sync[STAGES-2:0], pad_swap};
        end
    end

    // pad swap as a plain mux on the last stage
    assign sync_pad1 = swap_sync[STAGES-1] ? pad2_sync[STAGES-1] : pad1_sync[STAGES-1];
    assign sync_pad2 = swap_sync[STAGES-1] ? pad1_sync[STAGES-1] : pad2_sync[STAGES-1];

    ////////////////////////////////////////////////////////////
    // home combination
    ////////////////////////////////////////////////////////////

    // some pads report their home button as select + down
    always_ff @(posedge clk) begin
        if (!sys_resetn) begin
            home_press <= 1'b0;
        end else begin
            home_press <= sync_pad1.select & sync_pad1.down;  // one cycle behind sync_pad1
        end
    end

endmodule

//--- verilog/nes_pad_pkg.sv
// NES pad package
// button layouts shared along the controller path

`include "nes_pad_config.svh"

package nes_pad_pkg;

    ////////////////////////////////////////////////////////////
    // SNES style pad as delivered by the receivers
    ////////////////////////////////////////////////////////////

    typedef struct packed {
        logic shoulder_r;    // msb
        logic shoulder_l;
        logic turbo_b;       // autofire on NES b
        logic turbo_a;       // autofire on NES a
        logic right;
        logic left;
        logic down;
        logic up;
        logic start;
        logic select;
        logic b;
        logic a;             // lsb
    } snes_buttons_t;

    ////////////////////////////////////////////////////////////
    // NES joypad byte where a goes out first on the serial port
    ////////////////////////////////////////////////////////////

    typedef struct packed {
        logic right;
        logic left;
        logic down;
        logic up;
        logic start;
        logic select;
        logic b;
        logic a;
    } nes_buttons_t;

    // raw shift register view of the joypad byte
    typedef logic [`NES_PAD_BITS-1:0] nes_byte_t;

endpackage

//--- verilog/nes_pad_config.svh
// NES pad path configuration
// autofire timing, synchronizer depth and joypad byte width

`ifndef NES_PAD_CONFIG_SVH
`define NES_PAD_CONFIG_SVH

////////////////////////////////////////////////////////////
// autofire
////////////////////////////////////////////////////////////

// cycles high, then the same number of cycles low, while turbo is held
`define NES_PAD_TURBO_HALF 8

////////////////////////////////////////////////////////////
// pad input and joypad port
////////////////////////////////////////////////////////////

`define NES_PAD_SYNC_STAGES 2    // flops per synchronizer
`define NES_PAD_BITS        8    // bits in one NES joypad byte

`endif
